//--- disp_macros.svh
/*
 * Seven-segment display controller constants.
 * Digit count, scan dwell time, register offsets and the
 * bit positions inside the control register.
 */
`ifndef DISP_MACROS_SVH
`define DISP_MACROS_SVH

// Number of digits on the display, anything from 1 to 8 fits the register
`define DISP_DIGITS 4

// Clock cycles each digit stays lit during the scan
`define DISP_SCAN_DIV 16

// Register offsets on the AXI4-Lite bus
`define DISP_ADDR_DIGITS 4'h0
`define DISP_ADDR_CTRL 4'h4

// Control register bit positions
`define DISP_CTRL_LT 0
`define DISP_CTRL_BLANK_LEAD 1
`define DISP_CTRL_OFF 2

`endif

//--- disp_pkg.sv
/*
 * Shared types for the seven-segment display controller.
 * BCD digit code, active-low segment pattern and the
 * AXI4-Lite response code.
 */
`default_nettype none

package disp_pkg;

	// One BCD digit, codes 10 to 15 are legal and have their own glyphs
	typedef logic [3:0] bcd_t;

	// Active-low segments, bit 6 is segment a and bit 0 is segment g
	typedef logic [6:0] seg_t;

	// Only the two responses this slave can return
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_t;

endpackage

`default_nettype wire

//--- bcd_seg_decoder.sv
/*
 * 7447-style BCD to seven-segment decoder.
 * Active-low outputs with lamp test, ripple blanking and a
 * blanking input, all as separate one-way signals.
 */
`timescale 1ns/1ps
`default_nettype none

module bcd_seg_decoder (
	input  disp_pkg::bcd_t bcd,
	input  logic           lamp_test,
	input  logic           rbi,
	input  logic           bi,
	output disp_pkg::seg_t seg_n,
	output logic           rbo
);
	import disp_pkg::*;

	localparam seg_t SEG_DARK = 7'b1111111;
	localparam seg_t SEG_ALL  = 7'b0000000;

	always_comb begin
		rbo = 1'b0;
		// Blanking input wins over everything, lamp test included
		if (bi) begin
			seg_n = SEG_DARK;
		end else if (lamp_test) begin
			seg_n = SEG_ALL;
		end else if (rbi && bcd == 4'd0) begin
			// A zero behind blanked zeros goes dark and passes the blank down
			seg_n = SEG_DARK;
			rbo   = 1'b1;
		end else begin
			case (bcd)
				4'd0:    seg_n = 7'b0000001;
				4'd1:    seg_n = 7'b1001111;
				4'd2:    seg_n = 7'b0010010;
				4'd3:    seg_n = 7'b0000110;
				4'd4:    seg_n = 7'b1001100;
				4'd5:    seg_n = 7'b0100100;
				// The 7447 draws 6 and 9 without their tails
				4'd6:    seg_n = 7'b1100000;
				4'd7:    seg_n = 7'b0001111;
				4'd8:    seg_n = 7'b0000000;
				4'd9:    seg_n = 7'b0001100;
				// Codes 10 to 14 give the odd glyphs of the original part
				4'd10:   seg_n = 7'b1110010;
				4'd11:   seg_n = 7'b1100110;
				4'd12:   seg_n = 7'b1011100;
				4'd13:   seg_n = 7'b0110100;
				4'd14:   seg_n = 7'b1110000;
				// Code 15 is fully dark
				default: seg_n = SEG_DARK;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- disp_axi_regs.sv
/*
 * AXI4-Lite register block for the display controller.
 * Holds the packed digit register at offset 0x0 and the
 * control register at offset 0x4, with per-byte strobes.
 * Unmapped offsets answer SLVERR and leave state untouched.
 */
`timescale 1ns/1ps
`default_nettype none
`include "disp_macros.svh"

module disp_axi_regs (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [3:0]                        awaddr,
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [31:0]                       wdata,
	input  logic [3:0]                        wstrb,
	input  logic                              wvalid,
	output logic                              wready,
	output disp_pkg::axi_resp_t               bresp,
	output logic                              bvalid,
	input  logic                              bready,
	input  logic [3:0]                        araddr,
	input  logic                              arvalid,
	output logic                              arready,
	output logic [31:0]                       rdata,
	output disp_pkg::axi_resp_t               rresp,
	output logic                              rvalid,
	input  logic                              rready,
	output disp_pkg::bcd_t [`DISP_DIGITS-1:0] digits,
	output logic                              lamp_test,
	output logic                              blank_lead,
	output logic                              display_off
);
	import disp_pkg::*;

	localparam int DIGIT_BITS = `DISP_DIGITS * 4;

	bcd_t [`DISP_DIGITS-1:0] digit_q;
	logic [2:0]              ctrl_q;
	logic [31:0]             digit_word;
	logic [31:0]             ctrl_word;
	logic [31:0]             digit_merged;
	logic [31:0]             ctrl_merged;
	logic                    wr_accept;
	logic                    rd_accept;
	logic                    wr_digits;
	logic                    wr_ctrl;

	// Replace only the bytes whose strobe is set
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] result;
		result = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				result[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return result;
	endfunction

	// Registers as seen on the bus, unused upper bits read zero
	assign digit_word = 32'(digit_q);
	assign ctrl_word  = 32'(ctrl_q);

	assign digit_merged = merge_bytes(digit_word, wdata, wstrb);
	assign ctrl_merged  = merge_bytes(ctrl_word, wdata, wstrb);

	// Address and data are taken together and only with no response pending
	assign awready   = ~bvalid;
	assign wready    = ~bvalid;
	assign wr_accept = awvalid && wvalid && !bvalid;
	assign wr_digits = awaddr == `DISP_ADDR_DIGITS;
	assign wr_ctrl   = awaddr == `DISP_ADDR_CTRL;

	assign arready   = ~rvalid;
	assign rd_accept = arvalid && !rvalid;

	always_ff @(posedge clk) begin
		if (reset) begin
			digit_q <= '0;
			ctrl_q  <= '0;
			bvalid  <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			// New register value lands in the same edge that raises bvalid
			if (wr_accept) begin
				bvalid <= 1'b1;
				if (wr_digits) begin
					digit_q <= digit_merged[DIGIT_BITS-1:0];
				end
				if (wr_ctrl) begin
					ctrl_q <= ctrl_merged[2:0];
				end
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rd_accept) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Response payloads follow the accepted request
	always_ff @(posedge clk) begin
		if (wr_accept) begin
			bresp <= (wr_digits || wr_ctrl) ? OKAY : SLVERR;
		end
		if (rd_accept) begin
			if (araddr == `DISP_ADDR_DIGITS) begin
				rdata <= digit_word;
				rresp <= OKAY;
			end else if (araddr == `DISP_ADDR_CTRL) begin
				rdata <= ctrl_word;
				rresp <= OKAY;
			end else begin
				rdata <= '0;
				rresp <= SLVERR;
			end
		end
	end

	assign digits      = digit_q;
	assign lamp_test   = ctrl_q[`DISP_CTRL_LT];
	assign blank_lead  = ctrl_q[`DISP_CTRL_BLANK_LEAD];
	assign display_off = ctrl_q[`DISP_CTRL_OFF];

endmodule

`default_nettype wire

//--- digit_blank_chain.sv
/*
 * Decoder chain with leading-zero blanking.
 * The ripple blank runs from the most significant digit down,
 * and the segment patterns are registered once per clock.
 */
`timescale 1ns/1ps
`default_nettype none
`include "disp_macros.svh"

module digit_blank_chain (
	input  logic                              clk,
	input  logic                              reset,
	input  disp_pkg::bcd_t [`DISP_DIGITS-1:0] digits,
	input  logic                              lamp_test,
	input  logic                              blank_lead,
	input  logic                              display_off,
	output disp_pkg::seg_t [`DISP_DIGITS-1:0] patterns
);
	import disp_pkg::*;

	seg_t [`DISP_DIGITS-1:0] decoded;
	logic [`DISP_DIGITS-1:0] rbi;
	logic [`DISP_DIGITS-1:0] rbo;

	for (genvar i = 0; i < `DISP_DIGITS; i++) begin : g_digit
		// Digit 0 never blanks so a lone zero stays visible
		if (i == 0) begin : g_lsd
			assign rbi[i] = 1'b0;
		end else if (i == `DISP_DIGITS - 1) begin : g_msd
			assign rbi[i] = blank_lead;
		end else begin : g_mid
			assign rbi[i] = rbo[i+1];
		end

		bcd_seg_decoder u_dec (
			.bcd      (digits[i]),
			.lamp_test(lamp_test),
			.rbi      (rbi[i]),
			.bi       (display_off),
			.seg_n    (decoded[i]),
			.rbo      (rbo[i])
		);
	end

	// Patterns start dark and follow the registers one cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			patterns <= '1;
		end else begin
			patterns <= decoded;
		end
	end

endmodule

`default_nettype wire

//--- scan_mux.sv
/*
 * Scan multiplexer for the shared segment bus.
 * Each digit stays lit for a fixed dwell, from digit 0 upward,
 * with segments and active-low enables registered together.
 */
`timescale 1ns/1ps
`default_nettype none
`include "disp_macros.svh"

module scan_mux (
	input  logic                              clk,
	input  logic                              reset,
	input  disp_pkg::seg_t [`DISP_DIGITS-1:0] patterns,
	output disp_pkg::seg_t                    seg_n,
	output logic [`DISP_DIGITS-1:0]           dig_n
);
	import disp_pkg::*;

	localparam int IDX_W = (`DISP_DIGITS > 1) ? $clog2(`DISP_DIGITS) : 1;
	localparam int CNT_W = (`DISP_SCAN_DIV > 1) ? $clog2(`DISP_SCAN_DIV) : 1;

	logic [CNT_W-1:0]        dwell;
	logic [IDX_W-1:0]        idx;
	logic                    last_dwell;
	logic                    last_digit;
	logic [`DISP_DIGITS-1:0] select;
	seg_t                    current;

	assign last_dwell = dwell == CNT_W'(`DISP_SCAN_DIV - 1);
	assign last_digit = idx == IDX_W'(`DISP_DIGITS - 1);
	assign current    = patterns[idx];

	// One-hot select of the digit being lit
	always_comb begin
		select      = '0;
		select[idx] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dwell <= '0;
			idx   <= '0;
			seg_n <= '1;
			// Digit 0 is selected straight out of reset
			dig_n <= ~`DISP_DIGITS'(1);
		end else begin
			if (last_dwell) begin
				dwell <= '0;
				idx   <= last_digit ? '0 : idx + 1'b1;
			end else begin
				dwell <= dwell + 1'b1;
			end
			// Same edge for both so an enable never meets stale segments
			seg_n <= current;
			dig_n <= ~select;
		end
	end

endmodule

`default_nettype wire

//--- disp_top.sv
/*
 * Seven-segment display controller top level.
 * AXI4-Lite registers feed the decoder chain, whose patterns
 * are scanned onto the shared segment bus.
 */
`timescale 1ns/1ps
`default_nettype none
`include "disp_macros.svh"

module disp_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [3:0]              awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [31:0]             wdata,
	input  logic [3:0]              wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output disp_pkg::axi_resp_t     bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [3:0]              araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [31:0]             rdata,
	output disp_pkg::axi_resp_t     rresp,
	output logic                    rvalid,
	input  logic                    rready,
	output disp_pkg::seg_t          seg_n,
	output logic [`DISP_DIGITS-1:0] dig_n
);
	import disp_pkg::*;

	bcd_t [`DISP_DIGITS-1:0] digits;
	seg_t [`DISP_DIGITS-1:0] patterns;
	logic                    lamp_test;
	logic                    blank_lead;
	logic                    display_off;

	// Register decode from the host bus
	disp_axi_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.digits     (digits),
		.lamp_test  (lamp_test),
		.blank_lead (blank_lead),
		.display_off(display_off)
	);

	// Per-digit decode with leading-zero blanking
	digit_blank_chain u_chain (
		.clk        (clk),
		.reset      (reset),
		.digits     (digits),
		.lamp_test  (lamp_test),
		.blank_lead (blank_lead),
		.display_off(display_off),
		.patterns   (patterns)
	);

	scan_mux u_scan (
		.clk     (clk),
		.reset   (reset),
		.patterns(patterns),
		.seg_n   (seg_n),
		.dig_n   (dig_n)
	);

endmodule

`default_nettype wire

//--- tb_disp_top.sv
/*
 * Testbench for the seven-segment display controller.
 * Drives the AXI4-Lite slave, applies a table of digit and
 * control words and checks the scanned segment bus, register
 * readback, unmapped addresses and the digit scan order.
 */
`timescale 1ns/1ps
`default_nettype none
`include "disp_macros.svh"

module tb_disp_top;
	import disp_pkg::*;

	localparam int NUM_DIGITS  = `DISP_DIGITS;
	localparam int SCAN_CYCLES = `DISP_DIGITS * `DISP_SCAN_DIV;
	localparam int TIMEOUT     = 4 * SCAN_CYCLES + 100;

	localparam seg_t DARK = 7'b1111111;
	localparam seg_t LIT  = 7'b0000000;

	localparam logic [31:0] CTRL_LT   = 32'd1 << `DISP_CTRL_LT;
	localparam logic [31:0] CTRL_BL   = 32'd1 << `DISP_CTRL_BLANK_LEAD;
	localparam logic [31:0] CTRL_OFF  = 32'd1 << `DISP_CTRL_OFF;
	localparam logic [31:0] CTRL_MASK = 32'h7;
	// Four bits per digit are stored and the rest of the word reads zero
	localparam logic [31:0] DIGIT_MASK = (NUM_DIGITS >= 8) ? 32'hFFFF_FFFF :
		((32'd1 << (4 * NUM_DIGITS)) - 32'd1);

	logic                  clk;
	logic                  reset;
	logic [3:0]            awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [31:0]           wdata;
	logic [3:0]            wstrb;
	logic                  wvalid;
	logic                  wready;
	axi_resp_t             bresp;
	logic                  bvalid;
	logic                  bready;
	logic [3:0]            araddr;
	logic                  arvalid;
	logic                  arready;
	logic [31:0]           rdata;
	axi_resp_t             rresp;
	logic                  rvalid;
	logic                  rready;
	seg_t                  seg_n;
	logic [NUM_DIGITS-1:0] dig_n;

	// 7447 glyphs for codes 0 to 15 with segment a in the top bit
	seg_t seg_table [16];

	// Test table with one entry per index across the queues
	string                   case_name   [$];
	logic [31:0]             case_digits [$];
	logic [31:0]             case_ctrl   [$];
	seg_t [NUM_DIGITS-1:0]   case_exp    [$];

	disp_top uut (
		.clk    (clk),
		.reset  (reset),
		.awaddr (awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata  (wdata),
		.wstrb  (wstrb),
		.wvalid (wvalid),
		.wready (wready),
		.bresp  (bresp),
		.bvalid (bvalid),
		.bready (bready),
		.araddr (araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata  (rdata),
		.rresp  (rresp),
		.rvalid (rvalid),
		.rready (rready),
		.seg_n  (seg_n),
		.dig_n  (dig_n)
	);

	always #4 clk = ~clk;

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("ERR %s expected %b actual %b", name, expected, actual));
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_t expected,
		input axi_resp_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("ERR %s expected %b actual %b", name, expected, actual));
		end
	endtask

	task automatic check_data(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// Address and data go out together and the response is taken with a one-cycle bready
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output axi_resp_t resp);
		int cycles;
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		cycles  = 0;
		while (!(awready && wready)) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				stop_with_failure("The write address and data were never accepted");
			end
		end
		// Ready seen here means the handshake completes on the next rising edge
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		cycles  = 0;
		while (!bvalid) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				stop_with_failure("The write response never arrived");
			end
		end
		// The slave takes no new request while its response is pending
		check_data("write ready during response", 32'h0, {30'b0, awready, wready});
		resp   = bresp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
		output axi_resp_t resp);
		int cycles;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		cycles  = 0;
		while (!arready) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				stop_with_failure("The read address was never accepted");
			end
		end
		@(negedge clk);
		arvalid = 1'b0;
		cycles  = 0;
		while (!rvalid) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				stop_with_failure("The read data never arrived");
			end
		end
		check_data("read ready during response", 32'h0, {31'b0, arready});
		data   = rdata;
		resp   = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// Waits out a full scan so every digit carries its new pattern and then visits each digit
	task automatic check_display(input string name, input seg_t [NUM_DIGITS-1:0] expected);
		int                    cycles;
		logic [NUM_DIGITS-1:0] select_n;
		repeat (SCAN_CYCLES + 2) @(negedge clk);
		for (int i = 0; i < NUM_DIGITS; i++) begin
			select_n = ~(NUM_DIGITS'(1) << i);
			cycles   = 0;
			while (dig_n !== select_n) begin
				@(negedge clk);
				cycles++;
				if (cycles > TIMEOUT) begin
					stop_with_failure($sformatf("Digit %0d was never selected in %s", i, name));
				end
			end
			check_seg($sformatf("%s digit %0d", name, i), expected[i], seg_n);
		end
	endtask

	// Each change of dig_n must be the next single digit starting from digit 0
	task automatic check_scan_order();
		logic [NUM_DIGITS-1:0] prev;
		logic [NUM_DIGITS-1:0] expected;
		int                    cycles;
		prev     = dig_n;
		expected = ~NUM_DIGITS'(1);
		check_data("scan start", 32'(expected), 32'(prev));
		for (int step = 1; step <= NUM_DIGITS; step++) begin
			expected = ~(NUM_DIGITS'(1) << (step % NUM_DIGITS));
			cycles   = 0;
			while (dig_n === prev) begin
				@(negedge clk);
				cycles++;
				if (cycles > TIMEOUT) begin
					stop_with_failure("The digit scan stopped moving");
				end
			end
			prev = dig_n;
			check_data($sformatf("scan step %0d", step), 32'(expected), 32'(prev));
		end
	endtask

	task automatic add_case(input string name, input logic [31:0] digit_word,
		input logic [31:0] ctrl_word, input seg_t [NUM_DIGITS-1:0] expected);
		case_name.push_back(name);
		case_digits.push_back(digit_word);
		case_ctrl.push_back(ctrl_word);
		case_exp.push_back(expected);
	endtask

	// Expected patterns are listed most significant digit first
	task automatic build_table();
		for (int code = 0; code < 16; code++) begin
			add_case($sformatf("code %0d", code), 32'(code), 32'h0,
				{seg_table[0], seg_table[0], seg_table[0], seg_table[code]});
		end
		add_case("blank 0005", 32'h0005, CTRL_BL, {DARK, DARK, DARK, seg_table[5]});
		add_case("blank 0407", 32'h0407, CTRL_BL,
			{DARK, seg_table[4], seg_table[0], seg_table[7]});
		add_case("blank 0000", 32'h0000, CTRL_BL, {DARK, DARK, DARK, seg_table[0]});
		add_case("blank 1000", 32'h1000, CTRL_BL,
			{seg_table[1], seg_table[0], seg_table[0], seg_table[0]});
		add_case("no blank 0005", 32'h0005, 32'h0,
			{seg_table[0], seg_table[0], seg_table[0], seg_table[5]});
		add_case("no blank 0000", 32'h0000, 32'h0,
			{seg_table[0], seg_table[0], seg_table[0], seg_table[0]});
		add_case("lamp test", 32'h00F0, CTRL_LT, {LIT, LIT, LIT, LIT});
		add_case("lamp test over blank", 32'h0000, CTRL_LT | CTRL_BL, {LIT, LIT, LIT, LIT});
		add_case("display off", 32'h8888, CTRL_OFF, {DARK, DARK, DARK, DARK});
		add_case("off over lamp test", 32'h8888, CTRL_OFF | CTRL_LT, {DARK, DARK, DARK, DARK});
		add_case("back on", 32'h8888, 32'h0,
			{seg_table[8], seg_table[8], seg_table[8], seg_table[8]});
	endtask

	task automatic apply_case(input int n);
		axi_resp_t resp;
		axi_write(`DISP_ADDR_DIGITS, case_digits[n], 4'hF, resp);
		check_resp({case_name[n], " digit write"}, OKAY, resp);
		axi_write(`DISP_ADDR_CTRL, case_ctrl[n], 4'hF, resp);
		check_resp({case_name[n], " control write"}, OKAY, resp);
		check_display(case_name[n], case_exp[n]);
	endtask

	task automatic check_readback();
		logic [31:0] value;
		logic [31:0] data;
		axi_resp_t   resp;
		for (int k = 0; k < 8; k++) begin
			value = $urandom;
			axi_write(`DISP_ADDR_DIGITS, value, 4'hF, resp);
			check_resp($sformatf("digit write %0d", k), OKAY, resp);
			axi_read(`DISP_ADDR_DIGITS, data, resp);
			check_resp($sformatf("digit read %0d", k), OKAY, resp);
			check_data($sformatf("digit readback %0d", k), value & DIGIT_MASK, data);
			value = $urandom;
			axi_write(`DISP_ADDR_CTRL, value, 4'hF, resp);
			check_resp($sformatf("control write %0d", k), OKAY, resp);
			axi_read(`DISP_ADDR_CTRL, data, resp);
			check_resp($sformatf("control read %0d", k), OKAY, resp);
			check_data($sformatf("control readback %0d", k), value & CTRL_MASK, data);
		end
		// Each partial write leaves the bytes outside its strobes alone
		axi_write(`DISP_ADDR_DIGITS, 32'h0000_1234, 4'hF, resp);
		axi_write(`DISP_ADDR_DIGITS, 32'h0000_ABCD, 4'b0001, resp);
		check_resp("strobe low byte", OKAY, resp);
		axi_read(`DISP_ADDR_DIGITS, data, resp);
		check_data("strobe low byte", 32'h0000_12CD, data);
		axi_write(`DISP_ADDR_DIGITS, 32'h0000_5600, 4'b0010, resp);
		axi_read(`DISP_ADDR_DIGITS, data, resp);
		check_data("strobe second byte", 32'h0000_56CD, data);
		axi_write(`DISP_ADDR_CTRL, 32'h0000_0007, 4'hF, resp);
		axi_write(`DISP_ADDR_CTRL, 32'h0000_0000, 4'b0010, resp);
		axi_read(`DISP_ADDR_CTRL, data, resp);
		check_data("control strobe off", 32'h0000_0007, data);
		axi_write(`DISP_ADDR_CTRL, 32'h0000_0000, 4'b0001, resp);
		axi_read(`DISP_ADDR_CTRL, data, resp);
		check_data("control strobe on", 32'h0000_0000, data);
	endtask

	task automatic check_unmapped();
		logic [31:0] data;
		axi_resp_t   resp;
		axi_write(`DISP_ADDR_DIGITS, 32'h0000_1234, 4'hF, resp);
		axi_write(`DISP_ADDR_CTRL, 32'h0000_0000, 4'hF, resp);
		check_display("before unmapped",
			{seg_table[1], seg_table[2], seg_table[3], seg_table[4]});
		axi_write(4'h8, 32'hFFFF_FFFF, 4'hF, resp);
		check_resp("unmapped write 0x8", SLVERR, resp);
		axi_write(4'hC, 32'h0000_0005, 4'hF, resp);
		check_resp("unmapped write 0xC", SLVERR, resp);
		axi_read(4'h8, data, resp);
		check_resp("unmapped read 0x8", SLVERR, resp);
		check_data("unmapped read 0x8", 32'h0, data);
		axi_read(4'hC, data, resp);
		check_resp("unmapped read 0xC", SLVERR, resp);
		check_data("unmapped read 0xC", 32'h0, data);
		// Neither register nor display may have moved
		axi_read(`DISP_ADDR_DIGITS, data, resp);
		check_data("digits after unmapped", 32'h0000_1234, data);
		axi_read(`DISP_ADDR_CTRL, data, resp);
		check_data("control after unmapped", 32'h0000_0000, data);
		check_display("after unmapped",
			{seg_table[1], seg_table[2], seg_table[3], seg_table[4]});
	endtask

	initial begin
		void'($urandom(24180));
		clk       = 1'b0;
		reset     = 1'b1;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		seg_table = '{7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110,
			7'b1001100, 7'b0100100, 7'b1100000, 7'b0001111,
			7'b0000000, 7'b0001100, 7'b1110010, 7'b1100110,
			7'b1011100, 7'b0110100, 7'b1110000, 7'b1111111};
		build_table();
		repeat (16) @(negedge clk);
		reset = 1'b0;
		check_data("ready after reset", 32'h7, {29'b0, awready, wready, arready});
		check_data("valid after reset", 32'h0, {30'b0, bvalid, rvalid});
		check_scan_order();
		for (int n = 0; n < case_name.size(); n++) begin
			apply_case(n);
		end
		check_readback();
		check_unmapped();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
disp_pkg.sv
bcd_seg_decoder.sv
disp_axi_regs.sv
digit_blank_chain.sv
scan_mux.sv
disp_top.sv
tb_disp_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the display controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module tb_disp_top \
	&& ./obj_dir/Vtb_disp_top | tee sim.log \
	|| echo "Build or simulation ended with an error"
grep -q "ALL TESTS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
